// ==== pinmux_pkg.sv ====
// ----------------------------------------
// Shared constants for the pin mux block
// Bus widths, channel and pad counts
// Register map offsets and PWM pad map
// ----------------------------------------

package pinmux_pkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;

  // ----------------------------------------
  // Block sizing
  // ----------------------------------------
  // Pads 0..7 are port D, pads 8..15 are port B
  localparam int NUM_PWM    = 4;
  localparam int NUM_PADS   = 16;
  localparam int PWM_CNT_W  = 16;
  localparam int TICK_DIV_W = 10;

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] ADDR_GPIO_DIR   = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_GPIO_OUT   = 8'h04;
  // Read only, synchronized pad inputs
  localparam logic [ADDR_W-1:0] ADDR_GPIO_IN    = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_MULTI_FUNC = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_TICK_CFG   = 8'h10;
  // Channel n at base + 4n
  localparam logic [ADDR_W-1:0] ADDR_PWM_BASE   = 8'h20;

  // Pad driven by each PWM channel
  // Ch0 PD3, ch1 PD5, ch2 PD6, ch3 PB1
  localparam logic [NUM_PWM-1:0][$clog2(NUM_PADS)-1:0] PWM_PAD = {4'd9, 4'd6, 4'd5, 4'd3};

endpackage

// ==== pulse_gen.sv ====
// ----------------------------------------
// Microsecond tick generator
// One-cycle tick every D+1 mclk cycles
// ----------------------------------------

`timescale 1ns/100ps

module pulse_gen (
  input  logic                               mclk_i,
  input  logic                               arst_n_i,
  input  logic [pinmux_pkg::TICK_DIV_W-1:0]   tick_div_i,
  output logic                               tick_o
);
  import pinmux_pkg::*;

  // Cycles left until the next tick
  logic [TICK_DIV_W-1:0] cnt_q;

  // Divider sampled only at reload
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= tick_div_i;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== pwm_bank.sv ====
// ----------------------------------------
// PWM waveform generator bank
// Per channel high/low phases in ticks
// ----------------------------------------

`timescale 1ns/100ps

module pwm_bank (
  input  logic                                                 mclk_i,
  input  logic                                                 arst_n_i,
  input  logic                                                 tick_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0]                        pwm_enb_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0][pinmux_pkg::PWM_CNT_W-1:0] pwm_high_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0][pinmux_pkg::PWM_CNT_W-1:0] pwm_low_i,
  output logic [pinmux_pkg::NUM_PWM-1:0]                        pwm_wfm_o
);
  import pinmux_pkg::*;

  for (genvar i = 0; i < NUM_PWM; i++) begin : g_ch
    // Channel state
    logic                 run_q;
    logic                 phase_q;
    logic [PWM_CNT_W-1:0] cnt_q;
    logic [PWM_CNT_W-1:0] high_len;
    logic [PWM_CNT_W-1:0] low_len;
    logic [PWM_CNT_W-1:0] last_cnt;

    // Zero count behaves as one tick
    assign high_len = (pwm_high_i[i] == '0) ? PWM_CNT_W'(1) : pwm_high_i[i];
    assign low_len  = (pwm_low_i[i] == '0) ? PWM_CNT_W'(1) : pwm_low_i[i];
    assign last_cnt = phase_q ? high_len - 1'b1 : low_len - 1'b1;

    always_ff @(posedge mclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        run_q   <= 1'b0;
        phase_q <= 1'b0;
        cnt_q   <= '0;
      end else if (!pwm_enb_i[i]) begin
        // Idle, so re-enable restarts clean
        run_q   <= 1'b0;
        phase_q <= 1'b0;
        cnt_q   <= '0;
      end else if (tick_i) begin
        if (!run_q) begin
          // First tick after enable opens high phase
          run_q   <= 1'b1;
          phase_q <= 1'b1;
          cnt_q   <= '0;
        end else if (cnt_q == last_cnt) begin
          phase_q <= ~phase_q;
          cnt_q   <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    // Drops at once when the channel is disabled
    assign pwm_wfm_o[i] = pwm_enb_i[i] & phase_q;

    // Channel off for two cycles has fully idle state
    a_off_low: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
      !pwm_enb_i[i] && !$past(pwm_enb_i[i]) |-> !phase_q && !run_q && cnt_q == '0);
  end

endmodule

// ==== pad_mux.sv ====
// ----------------------------------------
// Pad output and output-enable mux
// PWM override, then GPIO direction
// ----------------------------------------

`timescale 1ns/100ps

module pad_mux (
  input  logic [pinmux_pkg::NUM_PWM-1:0]  pwm_enb_i,
  input  logic [pinmux_pkg::NUM_PWM-1:0]  pwm_wfm_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0] gpio_dir_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0] gpio_out_i,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_oen_o
);
  import pinmux_pkg::*;

  always_comb begin
    // Default every pad to input, driving 0
    pad_out_o = '0;
    pad_oen_o = '1;

    // GPIO outputs where direction says so
    for (int p = 0; p < NUM_PADS; p++) begin
      if (gpio_dir_i[p]) begin
        pad_out_o[p] = gpio_out_i[p];
        pad_oen_o[p] = 1'b0;
      end
    end

    // Enabled PWM takes its pad over
    for (int c = 0; c < NUM_PWM; c++) begin
      if (pwm_enb_i[c]) begin
        pad_out_o[PWM_PAD[c]] = pwm_wfm_i[c];
        pad_oen_o[PWM_PAD[c]] = 1'b0;
      end
    end
  end

endmodule

// ==== pinmux_reg.sv ====
// ----------------------------------------
// Configuration register file
// Four-phase cs/ack bus, GPIO input sync,
// read mux with unmapped offsets as zero
// ----------------------------------------

`timescale 1ns/100ps

module pinmux_reg (
  input  logic                                                 mclk_i,
  input  logic                                                 arst_n_i,
  input  logic                                                 reg_cs_i,
  input  logic                                                 reg_wr_i,
  input  logic [pinmux_pkg::ADDR_W-1:0]                         reg_addr_i,
  input  logic [pinmux_pkg::DATA_W-1:0]                         reg_wdata_i,
  output logic [pinmux_pkg::DATA_W-1:0]                         reg_rdata_o,
  output logic                                                 reg_ack_o,
  input  logic [pinmux_pkg::NUM_PADS-1:0]                       pad_in_i,
  output logic [pinmux_pkg::TICK_DIV_W-1:0]                     tick_div_o,
  output logic [pinmux_pkg::NUM_PWM-1:0]                        pwm_enb_o,
  output logic [pinmux_pkg::NUM_PWM-1:0][pinmux_pkg::PWM_CNT_W-1:0] pwm_high_o,
  output logic [pinmux_pkg::NUM_PWM-1:0][pinmux_pkg::PWM_CNT_W-1:0] pwm_low_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]                       gpio_dir_o,
  output logic [pinmux_pkg::NUM_PADS-1:0]                       gpio_out_o
);
  import pinmux_pkg::*;

  logic                bus_req;
  logic                wr_stb;
  logic [NUM_PWM-1:0]  pwm_sel;
  logic [DATA_W-1:0]   rd_mux;
  // Two-stage pad input synchronizer
  logic [NUM_PADS-1:0] gpio_in_meta;
  logic [NUM_PADS-1:0] gpio_in_sync;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  // New request: cs seen while ack still low
  assign bus_req = reg_cs_i & ~reg_ack_o;
  assign wr_stb  = bus_req & reg_wr_i;

  // Ack set by a request, cleared once cs drops
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_ack_o <= 1'b0;
    end else if (bus_req) begin
      reg_ack_o <= 1'b1;
    end else if (!reg_cs_i) begin
      reg_ack_o <= 1'b0;
    end
  end

  // Read data held for the whole ack phase
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rdata_o <= '0;
    end else if (bus_req) begin
      reg_rdata_o <= reg_wr_i ? '0 : rd_mux;
    end else if (!reg_cs_i) begin
      reg_rdata_o <= '0;
    end
  end

  // PWM channel decode, base + 4n
  always_comb begin
    for (int i = 0; i < NUM_PWM; i++) begin
      pwm_sel[i] = (reg_addr_i == ADDR_PWM_BASE + ADDR_W'(4 * i));
    end
  end

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_dir_o <= '0;
      gpio_out_o <= '0;
      pwm_enb_o  <= '0;
      tick_div_o <= '0;
      pwm_high_o <= '0;
      pwm_low_o  <= '0;
    end else if (wr_stb) begin
      case (reg_addr_i)
        ADDR_GPIO_DIR:   gpio_dir_o <= reg_wdata_i[NUM_PADS-1:0];
        ADDR_GPIO_OUT:   gpio_out_o <= reg_wdata_i[NUM_PADS-1:0];
        ADDR_MULTI_FUNC: pwm_enb_o  <= reg_wdata_i[NUM_PWM-1:0];
        ADDR_TICK_CFG:   tick_div_o <= reg_wdata_i[TICK_DIV_W-1:0];
        default: ;
      endcase
      // High count low half, low count upper half
      for (int i = 0; i < NUM_PWM; i++) begin
        if (pwm_sel[i]) begin
          pwm_high_o[i] <= reg_wdata_i[PWM_CNT_W-1:0];
          pwm_low_o[i]  <= reg_wdata_i[2*PWM_CNT_W-1:PWM_CNT_W];
        end
      end
    end
  end

  // Pad inputs are asynchronous to mclk
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_in_meta <= '0;
      gpio_in_sync <= '0;
    end else begin
      gpio_in_meta <= pad_in_i;
      gpio_in_sync <= gpio_in_meta;
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    rd_mux = '0;
    case (reg_addr_i)
      ADDR_GPIO_DIR:   rd_mux = DATA_W'(gpio_dir_o);
      ADDR_GPIO_OUT:   rd_mux = DATA_W'(gpio_out_o);
      ADDR_GPIO_IN:    rd_mux = DATA_W'(gpio_in_sync);
      ADDR_MULTI_FUNC: rd_mux = DATA_W'(pwm_enb_o);
      ADDR_TICK_CFG:   rd_mux = DATA_W'(tick_div_o);
      default:         rd_mux = '0;
    endcase
    for (int i = 0; i < NUM_PWM; i++) begin
      if (pwm_sel[i]) begin
        rd_mux = {pwm_low_o[i], pwm_high_o[i]};
      end
    end
  end

  // Ack only ever answers a request
  a_ack_needs_cs: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    $rose(reg_ack_o) |-> $past(reg_cs_i));

  // Ack released right after cs drops
  a_ack_release: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    reg_ack_o && !reg_cs_i |=> !reg_ack_o);

endmodule

// ==== pinmux_top.sv ====
// ----------------------------------------
// Pin mux top level
// Register file, tick generator, PWM bank
// and pad multiplexer
// ----------------------------------------

`timescale 1ns/100ps

module pinmux_top (
  input  logic                           mclk_i,
  input  logic                           arst_n_i,
  // Register bus
  input  logic                           reg_cs_i,
  input  logic                           reg_wr_i,
  input  logic [pinmux_pkg::ADDR_W-1:0]   reg_addr_i,
  input  logic [pinmux_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [pinmux_pkg::DATA_W-1:0]   reg_rdata_o,
  output logic                           reg_ack_o,
  // Pads
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_in_i,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_out_o,
  output logic [pinmux_pkg::NUM_PADS-1:0] pad_oen_o
);
  import pinmux_pkg::*;

  // Configuration from the register file
  logic [TICK_DIV_W-1:0]               tick_div;
  logic [NUM_PWM-1:0]                  pwm_enb;
  logic [NUM_PWM-1:0][PWM_CNT_W-1:0]   pwm_high;
  logic [NUM_PWM-1:0][PWM_CNT_W-1:0]   pwm_low;
  logic [NUM_PADS-1:0]                 gpio_dir;
  logic [NUM_PADS-1:0]                 gpio_out;
  // Microsecond tick and waveforms
  logic                                tick;
  logic [NUM_PWM-1:0]                  pwm_wfm;

  pinmux_reg u_reg (
    .mclk_i      (mclk_i),
    .arst_n_i    (arst_n_i),
    .reg_cs_i    (reg_cs_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_in_i    (pad_in_i),
    .tick_div_o  (tick_div),
    .pwm_enb_o   (pwm_enb),
    .pwm_high_o  (pwm_high),
    .pwm_low_o   (pwm_low),
    .gpio_dir_o  (gpio_dir),
    .gpio_out_o  (gpio_out)
  );

  pulse_gen u_tick (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .tick_div_i (tick_div),
    .tick_o     (tick)
  );

  pwm_bank u_pwm (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .tick_i     (tick),
    .pwm_enb_i  (pwm_enb),
    .pwm_high_i (pwm_high),
    .pwm_low_i  (pwm_low),
    .pwm_wfm_o  (pwm_wfm)
  );

  pad_mux u_pad (
    .pwm_enb_i  (pwm_enb),
    .pwm_wfm_i  (pwm_wfm),
    .gpio_dir_i (gpio_dir),
    .gpio_out_i (gpio_out),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o)
  );

endmodule

// ==== pinmux_checker.sv ====
// ----------------------------------------
// Testbench checker for the pin mux block
// Register model from observed bus writes
// Ack, read data, pad rule, PWM intervals
// ----------------------------------------

`timescale 1ns/100ps

module pinmux_checker (
  input  logic                            mclk_i,
  input  logic                            arst_n_i,
  input  logic                            reg_cs_i,
  input  logic                            reg_wr_i,
  input  logic [pinmux_pkg::ADDR_W-1:0]   reg_addr_i,
  input  logic [pinmux_pkg::DATA_W-1:0]   reg_wdata_i,
  input  logic [pinmux_pkg::DATA_W-1:0]   reg_rdata_i,
  input  logic                            reg_ack_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_in_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_out_i,
  input  logic [pinmux_pkg::NUM_PADS-1:0] pad_oen_i,
  output int                              err_cnt_o,
  output int                              chk_cnt_o
);
  import pinmux_pkg::*;

  // Register model
  logic [15:0] m_dir;
  logic [15:0] m_out;
  logic [3:0]  m_enb;
  logic [9:0]  m_div;
  logic [15:0] m_high [NUM_PWM];
  logic [15:0] m_low  [NUM_PWM];
  // Pad input history, two edges deep
  logic [15:0] in_d1;
  logic [15:0] in_d2;
  // Bus state
  logic        cs_q;
  logic        rd_pend;
  logic [31:0] rd_exp;
  // Per channel interval tracking
  logic        trk_lvl   [NUM_PWM];
  logic        trk_first [NUM_PWM];
  int          trk_len   [NUM_PWM];

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("[FAIL] %s exp 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic clear_model();
    m_dir   = '0;
    m_out   = '0;
    m_enb   = '0;
    m_div   = '0;
    in_d1   = '0;
    in_d2   = '0;
    cs_q    = 1'b0;
    rd_pend = 1'b0;
    rd_exp  = '0;
    for (int c = 0; c < NUM_PWM; c++) begin
      m_high[c]    = '0;
      m_low[c]     = '0;
      trk_lvl[c]   = 1'b0;
      trk_first[c] = 1'b1;
      trk_len[c]   = 0;
    end
  endtask

  // Read value by the register map, unused bits zero
  function automatic logic [31:0] model_read(input logic [7:0] addr);
    logic [31:0] val;
    case (addr)
      ADDR_GPIO_DIR:   val = {16'h0, m_dir};
      ADDR_GPIO_OUT:   val = {16'h0, m_out};
      ADDR_GPIO_IN:    val = {16'h0, in_d2};
      ADDR_MULTI_FUNC: val = {28'h0, m_enb};
      ADDR_TICK_CFG:   val = {22'h0, m_div};
      default:         val = '0;
    endcase
    for (int c = 0; c < NUM_PWM; c++) begin
      if (addr == ADDR_PWM_BASE + ADDR_W'(4 * c)) val = {m_low[c], m_high[c]};
    end
    return val;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
      ADDR_GPIO_DIR: m_dir = data[15:0];
      ADDR_GPIO_OUT: m_out = data[15:0];
      ADDR_TICK_CFG: m_div = data[9:0];
      ADDR_MULTI_FUNC: begin
        // Fresh enable, skip the wait for the first tick
        for (int c = 0; c < NUM_PWM; c++) begin
          if (data[c] && !m_enb[c]) begin
            trk_lvl[c]   = 1'b0;
            trk_first[c] = 1'b1;
            trk_len[c]   = 0;
          end
        end
        m_enb = data[3:0];
      end
      default: ;
    endcase
    for (int c = 0; c < NUM_PWM; c++) begin
      if (addr == ADDR_PWM_BASE + ADDR_W'(4 * c)) begin
        m_high[c] = data[15:0];
        m_low[c]  = data[31:16];
      end
    end
  endtask

  // Ticks per phase times cycles per tick, zero counts as one
  function automatic int phase_len(input logic [15:0] cnt);
    return ((cnt == '0) ? 1 : int'(cnt)) * (int'(m_div) + 1);
  endfunction

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    clear_model();
  end

  // Sampled on the rising edge, before the DUT flops update
  always @(posedge mclk_i) begin : watch
    logic [15:0] exp_out;
    logic [15:0] exp_oen;
    logic        lvl;
    int          pad;
    if (!arst_n_i) clear_model();

    // ----------------------------------------
    // Bus handshake and read data
    // ----------------------------------------
    compare("reg_ack_o", {31'h0, cs_q}, {31'h0, reg_ack_i});
    if (!reg_ack_i) begin
      compare("reg_rdata_o", '0, reg_rdata_i);
    end else if (rd_pend) begin
      compare("reg_rdata_o", rd_exp, reg_rdata_i);
    end

    // ----------------------------------------
    // Pad rule, PWM pads take observed level
    // ----------------------------------------
    exp_oen = ~m_dir;
    exp_out = m_dir & m_out;
    for (int c = 0; c < NUM_PWM; c++) begin
      pad = int'(PWM_PAD[c]);
      if (m_enb[c]) begin
        exp_oen[pad] = 1'b0;
        exp_out[pad] = pad_out_i[pad];
      end
    end
    compare("pad_oen_o", {16'h0, exp_oen}, {16'h0, pad_oen_i});
    compare("pad_out_o", {16'h0, exp_out}, {16'h0, pad_out_i});

    // Interval lengths on enabled channels
    for (int c = 0; c < NUM_PWM; c++) begin
      pad = int'(PWM_PAD[c]);
      lvl = pad_out_i[pad];
      if (m_enb[c] && lvl !== trk_lvl[c]) begin
        if (!trk_first[c]) begin
          compare($sformatf("pad_out_o[%0d] %s interval", pad, trk_lvl[c] ? "high" : "low"),
                  32'(phase_len(trk_lvl[c] ? m_high[c] : m_low[c])), 32'(trk_len[c]));
        end
        trk_first[c] = 1'b0;
        trk_lvl[c]   = lvl;
        trk_len[c]   = 1;
      end else if (m_enb[c]) begin
        trk_len[c] = trk_len[c] + 1;
      end
    end

    // New request, registers take writes on this edge
    if (arst_n_i && reg_cs_i && !reg_ack_i) begin
      rd_pend = !reg_wr_i;
      rd_exp  = model_read(reg_addr_i);
      if (reg_wr_i) model_write(reg_addr_i, reg_wdata_i);
    end
    cs_q = arst_n_i & reg_cs_i;
    if (arst_n_i) begin
      in_d2 = in_d1;
      in_d1 = pad_in_i;
    end
  end

endmodule

// ==== tb_pinmux.sv ====
// ----------------------------------------
// Testbench top for the pin mux block
// Clock, reset, seeded random bus traffic
// Test sequence and watchdog
// ----------------------------------------

`timescale 1ns/100ps

module tb_pinmux;
  import pinmux_pkg::*;

  localparam logic [31:0] SEED = 32'hf309;
  localparam int N_IN     = 10;
  localparam int N_MUX    = 20;
  localparam int MUX_WAIT = 24;
  localparam int N_ROUNDS = 3;
  localparam int N_TOGGLE = 4;
  // Longest period, counts up to 15 and up to 8 cycles per tick
  localparam int MAX_PERIOD   = 2 * 15 * 8;
  localparam int RUN_CYC      = 3 * MAX_PERIOD;
  localparam int TEST_CYC     = 400 + N_IN * 8 + N_MUX * (MUX_WAIT + 20)
                                + (N_ROUNDS + N_TOGGLE) * (RUN_CYC + 80);
  localparam int WATCHDOG_CYC = 2 * TEST_CYC;

  logic                mclk;
  logic                arst_n;
  logic                reg_cs;
  logic                reg_wr;
  logic [ADDR_W-1:0]   reg_addr;
  logic [DATA_W-1:0]   reg_wdata;
  logic [DATA_W-1:0]   reg_rdata;
  logic                reg_ack;
  logic [NUM_PADS-1:0] pad_in;
  logic [NUM_PADS-1:0] pad_out;
  logic [NUM_PADS-1:0] pad_oen;
  int                  err_cnt;
  int                  chk_cnt;
  int                  test_cnt;

  // 8 ns clock
  always #4 mclk = ~mclk;

  pinmux_top i_pinmux_top (
    .mclk_i      (mclk),
    .arst_n_i    (arst_n),
    .reg_cs_i    (reg_cs),
    .reg_wr_i    (reg_wr),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_ack_o   (reg_ack),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oen_o   (pad_oen)
  );

  pinmux_checker u_checker (
    .mclk_i      (mclk),
    .arst_n_i    (arst_n),
    .reg_cs_i    (reg_cs),
    .reg_wr_i    (reg_wr),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_i (reg_rdata),
    .reg_ack_i   (reg_ack),
    .pad_in_i    (pad_in),
    .pad_out_i   (pad_out),
    .pad_oen_i   (pad_oen),
    .err_cnt_o   (err_cnt),
    .chk_cnt_o   (chk_cnt)
  );

  // Four-phase transfer, driven on falling edges
  task automatic bus_cycle(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    @(negedge mclk);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_wdata = data;
    while (reg_ack !== 1'b1) @(negedge mclk);
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    while (reg_ack !== 1'b0) @(negedge mclk);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge mclk);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("Test %0d %s finished, errors so far %0d", test_cnt, name, err_cnt);
  endtask

  // Divider 0..7, high and low counts 1..15 per channel
  task automatic load_pwm();
    logic [15:0] hi;
    logic [15:0] lo;
    bus_cycle(1'b1, ADDR_TICK_CFG, 32'($urandom_range(7, 0)));
    for (int c = 0; c < NUM_PWM; c++) begin
      hi = 16'($urandom_range(15, 1));
      lo = 16'($urandom_range(15, 1));
      bus_cycle(1'b1, ADDR_PWM_BASE + ADDR_W'(4 * c), {lo, hi});
    end
  endtask

  initial begin : main
    int c;
    mclk      = 1'b0;
    arst_n    = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    pad_in    = '0;
    test_cnt  = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge mclk);
    @(negedge mclk);
    arst_n = 1'b1;
    wait_cycles(4);
    end_test("reset state");

    // Random register contents, PWM enables written last
    bus_cycle(1'b1, ADDR_MULTI_FUNC, '0);
    bus_cycle(1'b1, ADDR_GPIO_DIR, $urandom);
    bus_cycle(1'b1, ADDR_GPIO_OUT, $urandom);
    bus_cycle(1'b1, ADDR_TICK_CFG, $urandom);
    bus_cycle(1'b1, ADDR_GPIO_IN, $urandom);
    bus_cycle(1'b1, 8'h14, $urandom);
    for (int i = 0; i < NUM_PWM; i++) bus_cycle(1'b1, ADDR_PWM_BASE + ADDR_W'(4 * i), $urandom);
    bus_cycle(1'b1, ADDR_MULTI_FUNC, $urandom);
    for (int a = 0; a < 'h40; a += 4) bus_cycle(1'b0, ADDR_W'(a), '0);
    bus_cycle(1'b1, ADDR_MULTI_FUNC, '0);
    end_test("register access");

    // Pad inputs held 3 cycles before the read
    repeat (N_IN) begin
      pad_in = 16'($urandom);
      wait_cycles(3);
      bus_cycle(1'b0, ADDR_GPIO_IN, '0);
    end
    end_test("gpio input");

    load_pwm();
    repeat (N_MUX) begin
      bus_cycle(1'b1, ADDR_GPIO_DIR, $urandom);
      bus_cycle(1'b1, ADDR_GPIO_OUT, $urandom);
      bus_cycle(1'b1, ADDR_MULTI_FUNC, 32'($urandom_range(15, 0)));
      wait_cycles(MUX_WAIT);
    end
    bus_cycle(1'b1, ADDR_MULTI_FUNC, '0);
    end_test("pad mux");

    // Settings change only while all channels are off
    repeat (N_ROUNDS) begin
      load_pwm();
      bus_cycle(1'b1, ADDR_MULTI_FUNC, 32'hf);
      wait_cycles(RUN_CYC);
      bus_cycle(1'b1, ADDR_MULTI_FUNC, '0);
    end
    end_test("pwm timing");

    load_pwm();
    bus_cycle(1'b1, ADDR_GPIO_DIR, $urandom);
    bus_cycle(1'b1, ADDR_GPIO_OUT, $urandom);
    bus_cycle(1'b1, ADDR_MULTI_FUNC, 32'hf);
    repeat (N_TOGGLE) begin
      c = $urandom_range(3, 0);
      bus_cycle(1'b1, ADDR_MULTI_FUNC, 32'hf & ~(32'd1 << c));
      wait_cycles($urandom_range(20, 1));
      bus_cycle(1'b1, ADDR_MULTI_FUNC, 32'hf);
      wait_cycles(RUN_CYC);
    end
    end_test("pwm re-enable");

    $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge mclk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== flist.f ====
pinmux_pkg.sv
pulse_gen.sv
pwm_bank.sv
pad_mux.sv
pinmux_reg.sv
pinmux_top.sv
pinmux_checker.sv
tb_pinmux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pinmux
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
